/* compile.f */
hdl/board_pkg.sv
hdl/i2c_pkg.sv
hdl/tick_divider.sv
hdl/key_debounce.sv
hdl/led_control.sv
hdl/i2c_master.sv
hdl/adc_reader.sv
hdl/key_adc_top.sv
testbench/key_adc_chk.sv
testbench/key_adc_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the key_adc testbench with Verilator.
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module key_adc_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/Vkey_adc_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "test failed" "$log"; then
	exit 1
fi
if ! grep -q "test passed" "$log"; then
	echo "no result line found in $log"
	exit 1
fi
exit 0

/* testbench/key_adc_tb.sv */
/*
 * Testbench for key_adc_top with an I2C slave model on the bus.
 * Fast tick and 1 MHz bus keep the run short, checks are mostly in key_adc_chk.
 */
module key_adc_tb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int clk_hz = 25_000_000;
	localparam int tick_hz = 1_000_000;
	localparam int debounce_ticks = 20;
	localparam int scl_hz = 1_000_000;
	localparam int n = board_pkg::key_count;
	localparam int tick_cyc = clk_hz / tick_hz;
	localparam int hold_cyc = (debounce_ticks + 10) * tick_cyc;
	localparam int read_cyc = 48 * (clk_hz / scl_hz);	// one full transfer and then some
	localparam int max_cycles = 4 * (16 + 14 * hold_cyc + 4 * read_cyc);
	localparam board_pkg::key_vec_t released = '1;

	logic sys_clk;
	logic sys_rst_n;
	board_pkg::key_vec_t key_in;
	logic en_read;
	board_pkg::led_vec_t led;
	i2c_pkg::byte_t adc_data;
	logic adc_data_vld;
	logic adc_nack;
	wire scl;
	wire sda;

	logic [31:0] lfsr = 32'hf155;
	logic nack_addr;		// slave ignores its address
	logic sda_low = 1'b0;
	logic scl_d;
	logic sda_d;
	logic [3:0] nbits;		// scl rises in the current byte
	logic [1:0] byte_no;
	logic [1:0] start_no;
	logic read_mode;
	logic sending;
	i2c_pkg::byte_t rx_sh;
	i2c_pkg::byte_t tx_sh;
	i2c_pkg::byte_t model_byte;
	i2c_pkg::byte_t last_data;
	board_pkg::key_vec_t toggle_exp;
	int cycles = 0;
	int vld_cnt = 0;
	int proto_err = 0;
	int err_cnt;
	int err_mark;
	int fail_cnt;

	pullup (scl);
	pullup (sda);
	assign sda = sda_low ? 1'b0 : 1'bz;

	key_adc_top #(
		.clk_hz(clk_hz),
		.tick_hz(tick_hz),
		.debounce_ticks(debounce_ticks),
		.scl_hz(scl_hz)
	) key_adc_top_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.key_in(key_in),
		.en_read(en_read),
		.led(led),
		.adc_data(adc_data),
		.adc_data_vld(adc_data_vld),
		.adc_nack(adc_nack),
		.scl(scl),
		.sda(sda)
	);

	bind key_adc_top key_adc_chk #(
		.debounce_ticks(debounce_ticks),
		.tick_cycles(clk_hz / tick_hz)
	) key_adc_chk_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.key_in(key_in),
		.start(start),
		.led(led),
		.adc_data(adc_data),
		.adc_data_vld(adc_data_vld),
		.adc_nack(adc_nack),
		.scl(scl),
		.sda(sda)
	);

	initial begin
		sys_clk = 1'b0;
		forever #20 sys_clk = ~sys_clk;
	end

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic board_pkg::key_vec_t key_bit(input int i);
		return board_pkg::key_vec_t'(1) << i;
	endfunction

	// compares, protocol errors and assertion failures together
	function automatic int total_errors();
		return err_cnt + proto_err + key_adc_top_i.key_adc_chk_i.fails;
	endfunction

	// slave model, sampled on the system clock
	always @(posedge sys_clk) begin : slave_model
		logic [31:0] s;
		i2c_pkg::byte_t b;
		s = lfsr;
		b = '0;
		if (!sys_rst_n) begin
			nbits <= '0;
			byte_no <= '0;
			start_no <= '0;
			read_mode <= 1'b0;
			sending <= 1'b0;
			sda_low <= 1'b0;
		end else if (scl_d && scl && sda_d && !sda) begin	// start or restart
			nbits <= '0;
			byte_no <= '0;
			start_no <= start_no + 1'b1;
			read_mode <= 1'b0;
			sending <= 1'b0;
			sda_low <= 1'b0;
		end else if (scl_d && scl && !sda_d && sda) begin	// stop
			nbits <= '0;
			start_no <= '0;
			sending <= 1'b0;
			sda_low <= 1'b0;
		end else if (!scl_d && scl) begin
			rx_sh <= {rx_sh[6:0], sda};
			nbits <= nbits + 1'b1;
			if (sending && nbits == 4'd8 && !sda) begin
				proto_err <= proto_err + 1;
				$display("master acked the data byte instead of sending a nack");
			end
		end else if (scl_d && !scl) begin
			if (nbits == 4'd8) begin
				if (sending) begin
					sda_low <= 1'b0;	// master answers
				end else if (byte_no == 2'd0) begin
					if (rx_sh[7:1] != i2c_pkg::device_id || rx_sh[0] != (start_no == 2'd2)) begin
						proto_err <= proto_err + 1;
						$display("error at %0t: address byte expected %h got %h", $time,
							{i2c_pkg::device_id, start_no == 2'd2}, rx_sh);
					end
					sda_low <= !nack_addr;
					read_mode <= rx_sh[0] && !nack_addr;
					if (rx_sh[0] && !nack_addr) begin
						for (int i = 0; i < 8; i++) begin
							s = lfsr_step(s);
							b = {b[6:0], s[0]};
						end
						lfsr <= s;
						tx_sh <= b;
						model_byte <= b;
					end
				end else begin
					if (rx_sh != i2c_pkg::reg_addr) begin
						proto_err <= proto_err + 1;
						$display("error at %0t: reg pointer expected %h got %h", $time,
							i2c_pkg::reg_addr, rx_sh);
					end
					sda_low <= 1'b1;
				end
			end else if (nbits == 4'd9) begin
				nbits <= '0;
				byte_no <= byte_no + 1'b1;
				sending <= read_mode && !sending;
				sda_low <= read_mode && !sending && !tx_sh[7];	// first data bit
				tx_sh <= {tx_sh[6:0], 1'b0};
			end else if (sending) begin
				sda_low <= !tx_sh[7];
				tx_sh <= {tx_sh[6:0], 1'b0};
			end
		end
		scl_d <= scl;
		sda_d <= sda;
	end

	always @(posedge sys_clk) begin
		if (adc_data_vld)
			vld_cnt <= vld_cnt + 1;
	end

	// run limit, four times the expected length
	always @(posedge sys_clk) begin
		cycles <= cycles + 1;
		if (cycles == max_cycles) begin
			$display("timeout after %0d cycles, the run did not finish", cycles);
			$display("test failed");
			$finish;
		end
	end

	task automatic hold_keys(input board_pkg::key_vec_t keys_n);
		@(posedge sys_clk);
		key_in <= keys_n;
		while (led[n-1:0] == released)
			@(posedge sys_clk);
		repeat (4 * tick_cyc) @(posedge sys_clk);
	endtask

	task automatic release_keys();
		@(posedge sys_clk);
		key_in <= released;
		while (led[n-1:0] != released)
			@(posedge sys_clk);
		repeat (tick_cyc) @(posedge sys_clk);
	endtask

	task automatic expect_led(input board_pkg::led_vec_t exp);
		if (led !== exp) begin
			$display("error at %0t: led expected %b got %b", $time, exp, led);
			err_cnt++;
		end
	endtask

	task automatic pulse_read();
		@(posedge sys_clk);
		en_read <= 1'b1;
		@(posedge sys_clk);
		en_read <= 1'b0;
	endtask

	task automatic wait_result();
		while (!adc_data_vld && !adc_nack)
			@(posedge sys_clk);
	endtask

	task automatic report_test(input string name);
		int errs;
		errs = total_errors() - err_mark;
		if (errs != 0)
			fail_cnt++;
		$display("%s: %0d errors", name, errs);
		err_mark = total_errors();
	endtask

	initial begin
		sys_rst_n = 1'b0;
		key_in = released;
		en_read = 1'b0;
		nack_addr = 1'b0;
		toggle_exp = '1;
		err_cnt = 0;
		err_mark = 0;
		fail_cnt = 0;
		repeat (16) @(posedge sys_clk);
		sys_rst_n <= 1'b1;
		@(posedge sys_clk);
		expect_led('1);
		report_test("reset state");

		// two presses per key, the second one restores the toggle flag
		for (int i = 0; i < n; i++) begin
			repeat (2) begin
				hold_keys(~key_bit(i));
				toggle_exp = toggle_exp ^ key_bit(i);
				expect_led({toggle_exp, ~key_bit(i)});
				release_keys();
				expect_led({toggle_exp, released});
			end
		end
		report_test("single key press");

		for (int i = 0; i < n; i++) begin
			@(posedge sys_clk);
			key_in <= ~key_bit(i);
			repeat ((debounce_ticks / 2 + 2 * i) * tick_cyc) @(posedge sys_clk);
			key_in <= released;
			repeat (2 * tick_cyc) @(posedge sys_clk);
			expect_led({toggle_exp, released});
		end
		report_test("short bounce");

		hold_keys(4'b1001);		// keys 1 and 2 down
		toggle_exp = toggle_exp ^ key_bit(1);
		expect_led({toggle_exp, ~key_bit(1)});
		release_keys();
		expect_led({toggle_exp, released});
		report_test("two keys held");

		pulse_read();
		repeat (10 * (clk_hz / scl_hz)) @(posedge sys_clk);
		pulse_read();			// lands mid transfer
		wait_result();
		if (!adc_data_vld) begin
			$display("read ended with a nack although the slave answers");
			err_cnt++;
		end else if (adc_data !== model_byte) begin
			$display("error at %0t: adc_data expected %h got %h", $time, model_byte, adc_data);
			err_cnt++;
		end
		repeat (read_cyc) @(posedge sys_clk);
		if (vld_cnt != 1) begin
			$display("two reads requested mid transfer gave %0d results instead of 1", vld_cnt);
			err_cnt++;
		end
		report_test("adc read");

		last_data = adc_data;
		nack_addr <= 1'b1;
		pulse_read();
		wait_result();
		if (!adc_nack) begin
			$display("read finished without a nack although the slave refused it");
			err_cnt++;
		end else if (adc_data !== last_data) begin
			$display("error at %0t: adc_data expected %h got %h", $time, last_data, adc_data);
			err_cnt++;
		end
		@(posedge sys_clk);
		if (scl !== 1'b1 || sda !== 1'b1) begin
			$display("bus lines still held low after the stop");
			err_cnt++;
		end
		report_test("address nack");

		$display("6 tests run, %0d failed, %0d errors", fail_cnt, total_errors());
		if (fail_cnt == 0)
			$display("test passed");
		else
			$display("test failed");
		$finish;
	end

endmodule

/* testbench/key_adc_chk.sv */
/*
 * Concurrent checks bound into key_adc_top.
 * tick_cycles must match the clock to tick ratio of the DUT.
 */
module key_adc_chk #(
	parameter int debounce_ticks = 20,
	parameter int tick_cycles = 50_000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  board_pkg::key_vec_t key_in,
	input  logic start,
	input  board_pkg::led_vec_t led,
	input  i2c_pkg::byte_t adc_data,
	input  logic adc_data_vld,
	input  logic adc_nack,
	input  logic scl,
	input  logic sda
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int n = board_pkg::key_count;

	int low_run;			// cycles since any key went low
	logic [1:0] in_flight;		// accepted reads without a result yet
	int fails = 0;			// failed assertions so far

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n || key_in == '1)
			low_run <= 0;
		else
			low_run <= low_run + 1;
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			in_flight <= '0;
		else if (start && !(adc_data_vld || adc_nack))
			in_flight <= in_flight + 1'b1;
		else if (!start && (adc_data_vld || adc_nack))
			in_flight <= in_flight - 1'b1;
	end

	reset_state: assert property (@(posedge sys_clk)
		!sys_rst_n |=> (led == '1) && !adc_data_vld && !adc_nack &&
			(scl !== 1'b0) && (sda !== 1'b0))
	else begin
		$error("outputs are not at their reset values after reset");
		fails++;
	end

	// a lit held LED needs its key low before the sync and debounce delay
	held_leds: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$onehot0(~led[n-1:0]) &&
			((~led[n-1:0] & $past(key_in, 3) & $past(key_in, 5)) == '0))
	else begin
		$error("low LED nibble does not match the held key");
		fails++;
	end

	// toggle only when the held nibble lights from all off
	toggle_leds: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$past(sys_rst_n) |-> led[2*n-1:n] == ($past(led[2*n-1:n]) ^
			(($past(led[n-1:0]) == '1) ? ~led[n-1:0] : '0)))
	else begin
		$error("high LED nibble did not toggle once per press");
		fails++;
	end

	debounced: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		$fell(&led[n-1:0]) |-> low_run >= (debounce_ticks - 1) * tick_cycles)
	else begin
		$error("key shown before it was stable long enough");
		fails++;
	end

	result_once: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(adc_data_vld || adc_nack) |-> in_flight == 2'd1)
	else begin
		$error("read result without exactly one accepted read");
		fails++;
	end

	accept_idle: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		start |-> in_flight == 2'd0)
	else begin
		$error("read started while another was in flight");
		fails++;
	end

	keep_data: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		adc_nack |-> $stable(adc_data))
	else begin
		$error("adc_data changed on a nack");
		fails++;
	end

	bus_free: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		(adc_data_vld || adc_nack) |-> (scl !== 1'b0) && (sda !== 1'b0))
	else begin
		$error("bus not released after stop");
		fails++;
	end

endmodule

/* hdl/key_adc_top.sv */
/*
 * Board control top with key debounce, LEDs and the I2C ADC reader.
 * scl and sda are open drain, pull-ups are outside the chip.
 */
module key_adc_top #(
	parameter int clk_hz = 50_000_000,
	parameter int tick_hz = 1000,
	parameter int debounce_ticks = 20,
	parameter int scl_hz = 100_000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  board_pkg::key_vec_t key_in,
	input  logic en_read,
	output board_pkg::led_vec_t led,
	output i2c_pkg::byte_t adc_data,
	output logic adc_data_vld,
	output logic adc_nack,
	output logic scl,
	inout  logic sda
);

	logic tick;
	board_pkg::key_vec_t sta_key;
	board_pkg::key_vec_t sta_key_pos;
	logic start;
	i2c_pkg::byte_t rd_data;
	logic done;
	logic nack;

	tick_divider #(
		.clk_hz(clk_hz),
		.tick_hz(tick_hz)
	) tick_divider_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tick(tick)
	);

	key_debounce #(
		.debounce_ticks(debounce_ticks)
	) key_debounce_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.tick(tick),
		.key_in(key_in),
		.sta_key(sta_key),
		.sta_key_pos(sta_key_pos)
	);

	led_control led_control_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.sta_key(sta_key),
		.sta_key_pos(sta_key_pos),
		.led(led)
	);

	adc_reader adc_reader_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.en_read(en_read),
		.rd_data(rd_data),
		.done(done),
		.nack(nack),
		.start(start),
		.adc_data(adc_data),
		.adc_data_vld(adc_data_vld),
		.adc_nack(adc_nack)
	);

	i2c_master #(
		.clk_hz(clk_hz),
		.scl_hz(scl_hz)
	) i2c_master_i (
		.sys_clk(sys_clk),
		.sys_rst_n(sys_rst_n),
		.start(start),
		.rd_data(rd_data),
		.done(done),
		.nack(nack),
		.scl(scl),
		.sda(sda)
	);

endmodule

/* hdl/adc_reader.sv */
/*
 * Turns en_read into one bus read and registers the result.
 * en_read while a read is running is dropped, nothing is queued.
 */
module adc_reader (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic en_read,
	input  i2c_pkg::byte_t rd_data,
	input  logic done,
	input  logic nack,
	output logic start,
	output i2c_pkg::byte_t adc_data,
	output logic adc_data_vld,
	output logic adc_nack
);

	logic busy;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			busy <= 1'b0;
			start <= 1'b0;
		end else begin
			start <= en_read && !busy;	// accepted request
			if (done)
				busy <= 1'b0;
			else if (en_read)
				busy <= 1'b1;
		end
	end

	// result pulses one clock after done
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			adc_data_vld <= 1'b0;
			adc_nack <= 1'b0;
		end else begin
			adc_data_vld <= done && !nack;
			adc_nack <= done && nack;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (done && !nack)
			adc_data <= rd_data;	// keeps old byte on nack
	end

endmodule

/* hdl/i2c_master.sv */
/*
 * Open-drain I2C engine for one fixed pointer write then one-byte read.
 * No clock stretching and no arbitration, the bus is assumed single master.
 * scl and sda need external pull-ups. A failed address or pointer ACK ends in STOP with nack.
 */
module i2c_master #(
	parameter int clk_hz = 50_000_000,
	parameter int scl_hz = 100_000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic start,
	output i2c_pkg::byte_t rd_data,
	output logic done,
	output logic nack,
	output logic scl,
	inout  logic sda
);

	localparam int quarter = clk_hz / (4 * scl_hz);
	localparam int q_w = $clog2(quarter + 1);

	i2c_pkg::bus_state_t state;
	logic [q_w-1:0] qcnt;
	logic [1:0] phase;		// quarter within the current bit slot
	logic [2:0] bit_cnt;
	logic [1:0] seq;		// 0 addr write, 1 pointer, 2 addr read
	i2c_pkg::byte_t tx_sh;
	i2c_pkg::byte_t rx_sh;
	logic ack_bit;
	logic q_tick;
	logic slot_end;
	logic scl_rel;
	logic sda_rel;
	logic scl_q;
	logic sda_q;

	assign q_tick = (qcnt == q_w'(quarter - 1));
	assign slot_end = q_tick && (phase == 2'd3);

	// line levels per quarter, 1 lets the pull-up win
	always_comb begin
		scl_rel = (phase == 2'd1) || (phase == 2'd2);
		sda_rel = 1'b1;
		case (state)
			i2c_pkg::idle: scl_rel = 1'b1;
			i2c_pkg::start: begin
				scl_rel = (phase != 2'd3);
				sda_rel = (phase < 2'd2);	// falls while scl high
			end
			i2c_pkg::restart: sda_rel = (phase < 2'd2);
			i2c_pkg::send_byte: sda_rel = tx_sh[7];
			i2c_pkg::stop: begin
				scl_rel = (phase != 2'd0);
				sda_rel = (phase >= 2'd2);	// rises while scl high
			end
			default: sda_rel = 1'b1;	// ack, data and nack slots
		endcase
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			scl_q <= 1'b1;
			sda_q <= 1'b1;
		end else begin
			scl_q <= scl_rel;
			sda_q <= sda_rel;
		end
	end

	assign scl = scl_q ? 1'bz : 1'b0;
	assign sda = sda_q ? 1'bz : 1'b0;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= i2c_pkg::idle;
			qcnt <= '0;
			phase <= 2'd0;
			bit_cnt <= 3'd0;
			seq <= 2'd0;
			nack <= 1'b0;
			done <= 1'b0;
		end else begin
			done <= 1'b0;
			if (state == i2c_pkg::idle) begin
				qcnt <= '0;
				phase <= 2'd0;
				if (start) begin
					state <= i2c_pkg::start;
					seq <= 2'd0;
					nack <= 1'b0;
				end
			end else begin
				qcnt <= q_tick ? '0 : qcnt + 1'b1;
				if (q_tick)
					phase <= phase + 1'b1;
				if (slot_end) begin
					case (state)
						i2c_pkg::start, i2c_pkg::restart: begin
							state <= i2c_pkg::send_byte;
							bit_cnt <= 3'd7;
						end
						i2c_pkg::send_byte: begin
							if (bit_cnt == 3'd0)
								state <= i2c_pkg::get_ack;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						i2c_pkg::get_ack: begin
							bit_cnt <= 3'd7;
							if (ack_bit) begin
								nack <= 1'b1;	// abort the transfer
								state <= i2c_pkg::stop;
							end else begin
								seq <= seq + 1'b1;
								if (seq == 2'd0)
									state <= i2c_pkg::send_byte;
								else if (seq == 2'd1)
									state <= i2c_pkg::restart;
								else
									state <= i2c_pkg::recv_byte;
							end
						end
						i2c_pkg::recv_byte: begin
							if (bit_cnt == 3'd0)
								state <= i2c_pkg::send_nack;
							else
								bit_cnt <= bit_cnt - 1'b1;
						end
						i2c_pkg::send_nack: state <= i2c_pkg::stop;
						i2c_pkg::stop: begin
							state <= i2c_pkg::idle;
							done <= 1'b1;
						end
						default: state <= i2c_pkg::idle;
					endcase
				end
			end
		end
	end

	// shifters, sampled mid scl high
	always_ff @(posedge sys_clk) begin
		if (state == i2c_pkg::idle)
			tx_sh <= {i2c_pkg::device_id, 1'b0};	// write direction
		else if (slot_end && state == i2c_pkg::get_ack)
			tx_sh <= (seq == 2'd0) ? i2c_pkg::reg_addr : {i2c_pkg::device_id, 1'b1};
		else if (slot_end && state == i2c_pkg::send_byte)
			tx_sh <= {tx_sh[6:0], 1'b0};
		if (q_tick && phase == 2'd2 && state == i2c_pkg::get_ack)
			ack_bit <= sda;
		if (q_tick && phase == 2'd2 && state == i2c_pkg::recv_byte)
			rx_sh <= {rx_sh[6:0], sda};	// msb first
		if (slot_end && state == i2c_pkg::recv_byte && bit_cnt == 3'd0)
			rd_data <= rx_sh;
	end

endmodule

/* hdl/led_control.sv */
/*
 * LED driver, outputs lag the key codes by one clock.
 * Low nibble shows held keys, high nibble toggles once per press.
 */
module led_control (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  board_pkg::key_vec_t sta_key,
	input  board_pkg::key_vec_t sta_key_pos,
	output board_pkg::led_vec_t led
);

	localparam int n = board_pkg::key_count;

	// held indicators, lit only while the code is up
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			led[n-1:0] <= '1;
		else
			led[n-1:0] <= ~sta_key;
	end

	// toggle flags keep their state between presses
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			led[2*n-1:n] <= '1;
		else
			led[2*n-1:n] <= led[2*n-1:n] ^ sta_key_pos;
	end

endmodule

/* hdl/key_debounce.sv */
/*
 * Debounce for four active-low keys, key 0 has the highest priority.
 * Only one press pulse per hold, even if the winning key changes.
 */
module key_debounce #(
	parameter int debounce_ticks = 20
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic tick,
	input  board_pkg::key_vec_t key_in,
	output board_pkg::key_vec_t sta_key,
	output board_pkg::key_vec_t sta_key_pos
);

	localparam int cnt_w = $clog2(debounce_ticks + 1);

	board_pkg::key_vec_t key_meta;
	board_pkg::key_vec_t key_sync;
	logic [cnt_w-1:0] cnt;
	logic stable;
	logic held_q;

	// one-hot code of the lowest numbered low key
	function automatic board_pkg::key_vec_t pick_key(input board_pkg::key_vec_t keys_n);
		board_pkg::key_vec_t code;
		code = '0;
		for (int i = board_pkg::key_count - 1; i >= 0; i--) begin
			if (!keys_n[i])
				code = board_pkg::key_vec_t'(1) << i;	// lower index overrides
		end
		return code;
	endfunction

	assign stable = (cnt == cnt_w'(debounce_ticks));

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			key_meta <= '1;
			key_sync <= '1;
		end else begin
			key_meta <= key_in;	// async keys
			key_sync <= key_meta;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			cnt <= '0;
		else if (&key_sync)
			cnt <= '0;		// all released
		else if (tick && !stable)
			cnt <= cnt + 1'b1;	// saturates at debounce_ticks
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			sta_key <= '0;
			held_q <= 1'b0;
		end else begin
			sta_key <= stable ? pick_key(key_sync) : '0;
			held_q <= |sta_key;
		end
	end

	assign sta_key_pos = held_q ? '0 : sta_key;	// first cycle of a press

endmodule

/* hdl/tick_divider.sv */
/*
 * One-cycle tick every clk_hz/tick_hz clocks.
 * The ratio is truncated, so pick rates that divide evenly.
 */
module tick_divider #(
	parameter int clk_hz = 50_000_000,
	parameter int tick_hz = 1000
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	output logic tick
);

	localparam int period = clk_hz / tick_hz;
	localparam int cnt_w = $clog2(period + 1);

	logic [cnt_w-1:0] cnt;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cnt <= '0;
			tick <= 1'b0;
		end else if (cnt == cnt_w'(period - 1)) begin
			cnt <= '0;		// wrap and fire
			tick <= 1'b1;
		end else begin
			cnt <= cnt + 1'b1;
			tick <= 1'b0;
		end
	end

endmodule

/* hdl/i2c_pkg.sv */
/*
 * I2C definitions for the ADC reader.
 * Address and register pointer are fixed for the one converter on the bus.
 */
package i2c_pkg;

	typedef logic [7:0] byte_t;

	localparam logic [6:0] device_id = 7'b1010_100;	// 7-bit converter address
	localparam byte_t reg_addr = 8'h00;		// conversion result register

	// bit engine states
	typedef enum logic [2:0] {
		idle,
		start,
		send_byte,
		get_ack,
		restart,
		recv_byte,
		send_nack,
		stop
	} bus_state_t;

endpackage

/* hdl/board_pkg.sv */
/*
 * Key and LED definitions for the board control logic.
 * Keys and LEDs are both active low on the board.
 */
package board_pkg;

	localparam int key_count = 4;			// push keys on the board
	localparam int led_count = 2 * key_count;	// held nibble plus toggle nibble

	// one bit per key, raw level or one-hot code
	typedef logic [key_count-1:0] key_vec_t;

	// 1 turns the LED off
	typedef logic [led_count-1:0] led_vec_t;

endpackage
